// ==== compile.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/mem_pkg.sv
rtl/refill_if.sv
rtl/icache_ways.sv
rtl/icache_lru.sv
rtl/icache_refill.sv
rtl/icache_lookup.sv
rtl/icache_top.sv
verif/dram_model.sv
verif/tb_icache.sv

// ==== verif/tb_icache.sv ====
`timescale 1ns/10ps

`include "icache_macros.svh"

module tb_icache;

  localparam icache_pkg::word_t data_pattern   = 64'h5a3c_96e1_0f87_d24b;
  localparam int unsigned       seed           = 32'h3905_be3a;
  // about 230 fetches at under 30 cycles each plus a wide margin
  localparam int                timeout_cycles = 20000;

  logic              clk;
  logic              rst_n;
  icache_pkg::addr_t cpu_addr;
  logic              ins_req;
  icache_pkg::word_t instruction;
  logic              rom_abort;
  icache_pkg::word_t dram_data;
  logic              dram_val;
  logic              dram_req;
  icache_pkg::addr_t dram_req_addr;
  logic              slow;

  int                errors;
  int                checks;
  int                cycle_count;
  int                req_count;
  logic              req_seen;
  icache_pkg::addr_t last_req_addr;

  // reference copy of tags, valid bits and ages
  icache_pkg::tag_t  m_tag   [2][`ICACHE_SETS];
  logic              m_valid [2][`ICACHE_SETS];
  icache_pkg::age_t  m_age   [2][`ICACHE_SETS];

  icache_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_addr      (cpu_addr),
    .ins_req       (ins_req),
    .instruction   (instruction),
    .rom_abort     (rom_abort),
    .dram_data     (dram_data),
    .dram_val      (dram_val),
    .dram_req      (dram_req),
    .dram_req_addr (dram_req_addr)
  );

  dram_model #(.pattern(data_pattern)) u_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .slow          (slow),
    .dram_req      (dram_req),
    .dram_req_addr (dram_req_addr),
    .dram_val      (dram_val),
    .dram_data     (dram_data)
  );

  always #20 clk = ~clk;

  // count memory requests and check that a pending refill holds the cpu off
  always @(negedge clk) begin
    if (dram_req && !req_seen) begin
      req_count++;
      last_req_addr = dram_req_addr;
    end
    req_seen = dram_req;
    if (rst_n && dram_req) begin
      assert (rom_abort) else begin
        errors++;
        $display("rom_abort went low while dram_req was pending");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic icache_pkg::word_t word_at(icache_pkg::addr_t a);
    return {a[63:3], 3'b000} ^ data_pattern;
  endfunction

  task automatic check_value(input string test, input icache_pkg::word_t exp,
                             input icache_pkg::word_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", test, exp, got);
    end
  endtask

  task automatic check_cond(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic model_clear();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      for (int w = 0; w < 2; w++) begin
        m_valid[w][s] = 1'b0;
        m_age[w][s]   = '0;
      end
    end
  endtask

  // used way drops to zero while the other ages and saturates
  task automatic model_touch(input int s, input int w, input int times);
    repeat (times) begin
      m_age[w][s] = '0;
      if (m_age[1-w][s] != '1)
        m_age[1-w][s] = m_age[1-w][s] + 1'b1;
    end
  endtask

  task automatic model_access(input icache_pkg::addr_t a, output bit miss);
    int s;
    int w;
    s = a[10:5];
    w = -1;
    for (int i = 0; i < 2; i++)
      if (m_valid[i][s] && m_tag[i][s] == a[63:11])
        w = i;
    miss = (w < 0);
    if (miss) begin
      if (!m_valid[0][s])
        w = 0;
      else if (!m_valid[1][s])
        w = 1;
      else
        w = (m_age[0][s] > m_age[1][s]) ? 0 : 1;
      m_valid[w][s] = 1'b1;
      m_tag[w][s]   = a[63:11];
      // fill, hit after the reread, then the held request again
      model_touch(s, w, 3);
    end else begin
      model_touch(s, w, 2);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n   <= 1'b0;
    ins_req <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    model_clear();
  endtask

  task automatic fetch(input icache_pkg::addr_t a, output icache_pkg::word_t data,
                       output bit missed, output int aborts);
    missed = 1'b0;
    aborts = 0;
    @(posedge clk);
    ins_req  <= 1'b1;
    cpu_addr <= a;
    // request taken at this edge and result due half a cycle later
    @(posedge clk);
    @(negedge clk);
    while (rom_abort) begin
      missed = 1'b1;
      aborts++;
      @(negedge clk);
    end
    data = instruction;
    @(posedge clk);
    ins_req <= 1'b0;
  endtask

  task automatic fetch_check(input string test, input icache_pkg::addr_t a,
                             output bit missed);
    icache_pkg::word_t data;
    bit                exp_miss;
    int                aborts;
    model_access(a, exp_miss);
    fetch(a, data, missed, aborts);
    check_value(test, word_at(a), data);
    check_cond(missed == exp_miss,
               $sformatf("%s: hit or miss at %h differs from the reference model", test, a));
  endtask

  task automatic cold_miss_test();
    icache_pkg::addr_t a;
    bit                missed;
    int                reqs;
    a    = 64'h0000_1234_5678_0048;
    reqs = req_count;
    fetch_check("cold_miss", a, missed);
    check_cond(missed, "cold_miss: first fetch did not raise rom_abort");
    check_cond(req_count == reqs + 1, "cold_miss: dram_req did not rise exactly once");
    check_value("cold_miss_addr", {a[63:5], 5'b00000}, last_req_addr);
    fetch_check("cold_miss_second", a + 64'h10, missed);
    check_cond(!missed, "cold_miss: second fetch in the same line did not hit");
  endtask

  task automatic offsets_test();
    icache_pkg::addr_t base;
    bit                missed;
    base = 64'h0000_00ab_cdef_3460;
    for (int i = 0; i < `ICACHE_LINE_WORDS; i++)
      fetch_check($sformatf("offset_%0d", i), base + 64'(i * 8), missed);
  endtask

  task automatic two_way_test();
    icache_pkg::addr_t a;
    icache_pkg::addr_t b;
    bit                missed;
    int                reqs;
    a = 64'h0000_0001_0000_0120;
    b = 64'h0000_0002_0000_0128;
    fetch_check("two_way", a, missed);
    fetch_check("two_way", b, missed);
    reqs = req_count;
    fetch_check("two_way", a, missed);
    fetch_check("two_way", b, missed);
    check_cond(req_count == reqs, "two_way: refetch of a resident line went to memory");
  endtask

  task automatic replace_test();
    icache_pkg::addr_t a;
    icache_pkg::addr_t b;
    icache_pkg::addr_t c;
    bit                missed;
    int                reqs;
    a = 64'h0000_0010_0000_07c0;
    b = 64'h0000_0020_0000_07c8;
    c = 64'h0000_0030_0000_07d0;
    fetch_check("replace", a, missed);
    fetch_check("replace", b, missed);
    fetch_check("replace", a, missed);
    fetch_check("replace", c, missed);
    reqs = req_count;
    fetch_check("replace", a, missed);
    check_cond(req_count == reqs, "replace: recently used line was evicted");
    fetch_check("replace", b, missed);
    check_cond(missed && req_count == reqs + 1, "replace: oldest line was not evicted");
  endtask

  task automatic backpressure_reset_test();
    icache_pkg::addr_t a;
    icache_pkg::word_t data;
    bit                exp_miss;
    bit                missed;
    int                aborts;
    a    = 64'h0000_0bad_c0de_0300;
    slow <= 1'b1;
    model_access(a, exp_miss);
    fetch(a, data, missed, aborts);
    slow <= 1'b0;
    check_value("backpressure", word_at(a), data);
    check_cond(missed && exp_miss, "backpressure: slow refill did not raise rom_abort");
    // three gaps of six idle cycles between the beats
    check_cond(aborts > 3 * 6, "backpressure: rom_abort fell before the line arrived");
    // start a refill in another set and cut it off with the reset
    @(posedge clk);
    ins_req  <= 1'b1;
    cpu_addr <= a + 64'h400;
    @(negedge clk);
    while (!dram_req)
      @(negedge clk);
    apply_reset();
    @(negedge clk);
    check_cond(!dram_req && !rom_abort, "reset: dram_req or rom_abort high after reset");
    fetch_check("after_reset", 64'h0000_1234_5678_0048, missed);
    check_cond(missed, "reset: a line cached before the reset still hit");
  endtask

  task automatic random_sweep_test();
    icache_pkg::addr_t a;
    bit                missed;
    for (int i = 0; i < 200; i++) begin
      // 512 lines over all sets with eight tags per set
      a = 64'h0000_4000_0000_0000 + 64'(($urandom % 512) * 32) + 64'(($urandom % 4) * 8);
      fetch_check("random_sweep", a, missed);
    end
  endtask

  initial begin
    void'($urandom(seed));
    clk         = 1'b0;
    rst_n       = 1'b0;
    ins_req     = 1'b0;
    cpu_addr    = '0;
    slow        = 1'b0;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    req_count   = 0;
    req_seen    = 1'b0;
    apply_reset();
    cold_miss_test();
    offsets_test();
    two_way_test();
    replace_test();
    backpressure_reset_test();
    random_sweep_test();
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== verif/dram_model.sv ====
`timescale 1ns/10ps

module dram_model #(
  parameter icache_pkg::word_t pattern = '0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              slow,
  input  logic              dram_req,
  input  icache_pkg::addr_t dram_req_addr,
  output logic              dram_val,
  output icache_pkg::word_t dram_data
);

  // 0 waiting, 1 sending beats, 2 waiting for the request to drop
  int phase;
  int beat;
  int wait_cnt;

  initial begin
    dram_val  = 1'b0;
    dram_data = '0;
    phase     = 0;
    beat      = 0;
    wait_cnt  = 0;
  end

  always @(posedge clk) begin
    dram_val <= 1'b0;
    if (!rst_n) begin
      phase <= 0;
    end else if (phase == 0) begin
      if (dram_req) begin
        phase    <= 1;
        beat     <= 0;
        wait_cnt <= $urandom % 4;
      end
    end else if (phase == 1) begin
      if (wait_cnt > 0) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        dram_val  <= 1'b1;
        dram_data <= (dram_req_addr + 64'(beat * 8)) ^ pattern;
        beat      <= beat + 1;
        // slow mode stretches every gap to six cycles
        wait_cnt  <= slow ? 6 : $urandom % 2;
        if (beat == 3)
          phase <= 2;
      end
    end else if (!dram_req) begin
      phase <= 0;
    end
  end

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
  input  logic              clk,
  input  logic              rst_n,
  input  icache_pkg::addr_t cpu_addr,
  input  logic              ins_req,
  output icache_pkg::word_t instruction,
  output logic              rom_abort,
  input  icache_pkg::word_t dram_data,
  input  logic              dram_val,
  output logic              dram_req,
  output icache_pkg::addr_t dram_req_addr
);

  logic               rd_en;
  icache_pkg::index_t rd_index;
  icache_pkg::tag_t   way_tag0;
  icache_pkg::tag_t   way_tag1;
  logic               way_valid0;
  logic               way_valid1;
  icache_pkg::line_t  way_line0;
  icache_pkg::line_t  way_line1;
  logic               hit_en;
  logic               hit_way;
  logic               victim_way;
  logic               fill_way;

  refill_if u_rf ();

  icache_lookup u_lookup (
    .clk         (clk),
    .rst_n       (rst_n),
    .cpu_addr    (cpu_addr),
    .ins_req     (ins_req),
    .instruction (instruction),
    .rom_abort   (rom_abort),
    .rd_en       (rd_en),
    .rd_index    (rd_index),
    .way_tag0    (way_tag0),
    .way_tag1    (way_tag1),
    .way_valid0  (way_valid0),
    .way_valid1  (way_valid1),
    .way_line0   (way_line0),
    .way_line1   (way_line1),
    .hit_en      (hit_en),
    .hit_way     (hit_way),
    .rf          (u_rf.lookup)
  );

  icache_ways u_ways (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_en      (rd_en),
    .rd_index   (rd_index),
    .way_tag0   (way_tag0),
    .way_tag1   (way_tag1),
    .way_valid0 (way_valid0),
    .way_valid1 (way_valid1),
    .way_line0  (way_line0),
    .way_line1  (way_line1),
    .victim_way (victim_way),
    .fill_way   (fill_way),
    .st         (u_rf.store)
  );

  icache_lru u_lru (
    .clk        (clk),
    .rst_n      (rst_n),
    .hit_en     (hit_en),
    .hit_way    (hit_way),
    .st         (u_rf.store),
    .fill_way   (fill_way),
    .victim_way (victim_way)
  );

  icache_refill u_refill (
    .clk           (clk),
    .rst_n         (rst_n),
    .dram_data     (dram_data),
    .dram_val      (dram_val),
    .dram_req      (dram_req),
    .dram_req_addr (dram_req_addr),
    .rf            (u_rf.refill)
  );

endmodule

// ==== rtl/icache_lookup.sv ====
`timescale 1ns/10ps

module icache_lookup (
  input  logic               clk,
  input  logic               rst_n,
  input  icache_pkg::addr_t  cpu_addr,
  input  logic               ins_req,
  output icache_pkg::word_t  instruction,
  output logic               rom_abort,
  output logic               rd_en,
  output icache_pkg::index_t rd_index,
  input  icache_pkg::tag_t   way_tag0,
  input  icache_pkg::tag_t   way_tag1,
  input  logic               way_valid0,
  input  logic               way_valid1,
  input  icache_pkg::line_t  way_line0,
  input  icache_pkg::line_t  way_line1,
  output logic               hit_en,
  output logic               hit_way,
  refill_if.lookup           rf
);

  icache_pkg::addr_t   req_addr;
  logic                req_valid;
  logic                reread_q;
  icache_pkg::tag_t    req_tag;
  icache_pkg::index_t  req_index;
  icache_pkg::offset_t req_off;
  logic                hit0;
  logic                hit1;
  logic                hit;
  logic                accept;
  icache_pkg::line_t   sel_line;

  assign req_tag   = req_addr[icache_pkg::addr_w-1:icache_pkg::tag_lsb];
  assign req_index = req_addr[icache_pkg::tag_lsb-1:icache_pkg::line_lsb];
  assign req_off   = req_addr[icache_pkg::line_lsb-1:icache_pkg::byte_w];

  // cpu holds its request while rom_abort is high
  assign accept = ins_req & ~rom_abort;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      reread_q  <= 1'b0;
    end else begin
      reread_q <= rf.fill_valid;
      if (!rom_abort)
        req_valid <= ins_req;
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      req_addr <= cpu_addr;
  end

  // reread in the last busy cycle so fresh data lands as busy falls
  assign rd_en    = accept | reread_q;
  assign rd_index = reread_q ? req_index
                             : cpu_addr[icache_pkg::tag_lsb-1:icache_pkg::line_lsb];

  assign hit0 = way_valid0 & (way_tag0 == req_tag);
  assign hit1 = way_valid1 & (way_tag1 == req_tag);
  assign hit  = hit0 | hit1;

  assign rf.miss      = req_valid & ~hit & ~rf.busy;
  assign rf.miss_addr = req_addr;
  assign rom_abort    = (req_valid & ~hit) | rf.busy;

  assign hit_en  = req_valid & hit & ~rf.busy;
  assign hit_way = hit1;

  assign sel_line    = hit1 ? way_line1 : way_line0;
  assign instruction = sel_line[req_off * icache_pkg::word_w +: icache_pkg::word_w];

  // a line lives in one way only
  a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> !(hit0 && hit1));

endmodule

// ==== rtl/icache_refill.sv ====
`timescale 1ns/10ps

module icache_refill (
  input  logic              clk,
  input  logic              rst_n,
  input  icache_pkg::word_t dram_data,
  input  logic              dram_val,
  output logic              dram_req,
  output icache_pkg::addr_t dram_req_addr,
  refill_if.refill          rf
);

  mem_pkg::refill_state_e state;
  mem_pkg::beat_cnt_t     beat_cnt;
  icache_pkg::line_t      line_buf;
  logic                   tail_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= mem_pkg::idle;
      beat_cnt <= '0;
      dram_req <= 1'b0;
      tail_q   <= 1'b0;
    end else begin
      tail_q <= (state == mem_pkg::write);
      case (state)
        mem_pkg::idle: begin
          if (rf.miss) begin
            state    <= mem_pkg::fetch;
            beat_cnt <= '0;
            dram_req <= 1'b1;
          end
        end
        mem_pkg::fetch: begin
          if (dram_val) begin
            beat_cnt <= beat_cnt + 1'b1;
            // request drops as the last beat is taken
            if (beat_cnt == mem_pkg::last_beat) begin
              state    <= mem_pkg::write;
              dram_req <= 1'b0;
            end
          end
        end
        mem_pkg::write: state <= mem_pkg::idle;
        default:        state <= mem_pkg::idle;
      endcase
    end
  end

  // line-aligned address held for the whole request
  always_ff @(posedge clk) begin
    if (state == mem_pkg::idle && rf.miss)
      dram_req_addr <= {rf.miss_addr[icache_pkg::addr_w-1:icache_pkg::line_lsb],
                        {icache_pkg::line_lsb{1'b0}}};
  end

  // lowest word arrives first and ends up in the low bits
  always_ff @(posedge clk) begin
    if (state == mem_pkg::fetch && dram_val)
      line_buf <= {dram_data, line_buf[icache_pkg::line_w-1:icache_pkg::word_w]};
  end

  assign rf.fill_valid = (state == mem_pkg::write);
  assign rf.fill_line  = line_buf;
  // one extra cycle covers the array reread
  assign rf.busy       = (state != mem_pkg::idle) | tail_q;

  a_no_beat_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == mem_pkg::idle) |-> !dram_val);

  // a fifth beat would land in the write cycle
  a_beat_bound: assert property (@(posedge clk) disable iff (!rst_n)
    (state == mem_pkg::write) |-> !dram_val);

endmodule

// ==== rtl/icache_lru.sv ====
`timescale 1ns/10ps

module icache_lru (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     hit_en,
  input  logic     hit_way,
  refill_if.store  st,
  input  logic     fill_way,
  output logic     victim_way
);

  icache_pkg::age_t   age [2][icache_pkg::sets];
  icache_pkg::index_t set_index;
  logic               use_en;
  logic               use_way;

  // miss_addr follows the registered request, so it names the hit set too
  assign set_index = st.miss_addr[icache_pkg::tag_lsb-1:icache_pkg::line_lsb];

  // hits and fills never overlap, fill wins anyway
  assign use_en  = st.fill_valid | hit_en;
  assign use_way = st.fill_valid ? fill_way : hit_way;

  // ties go to way 1
  assign victim_way = (age[0][set_index] > age[1][set_index]) ? 1'b0 : 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < icache_pkg::sets; s++) begin
        age[0][s] <= '0;
        age[1][s] <= '0;
      end
    end else if (use_en) begin
      for (int w = 0; w < 2; w++) begin
        if (w == int'(use_way))
          age[w][set_index] <= '0;
        else if (age[w][set_index] != '1)
          age[w][set_index] <= age[w][set_index] + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/icache_ways.sv ====
`timescale 1ns/10ps

module icache_ways (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rd_en,
  input  icache_pkg::index_t rd_index,
  output icache_pkg::tag_t   way_tag0,
  output icache_pkg::tag_t   way_tag1,
  output logic               way_valid0,
  output logic               way_valid1,
  output icache_pkg::line_t  way_line0,
  output icache_pkg::line_t  way_line1,
  input  logic               victim_way,
  output logic               fill_way,
  refill_if.store            st
);

  icache_pkg::tag_t            tag_mem   [2][icache_pkg::sets];
  icache_pkg::line_t           line_mem  [2][icache_pkg::sets];
  logic [icache_pkg::sets-1:0] valid_mem [2];

  icache_pkg::tag_t            rd_tag    [2];
  icache_pkg::line_t           rd_line   [2];
  logic [1:0]                  rd_valid;

  icache_pkg::index_t          fill_index;
  icache_pkg::tag_t            fill_tag;

  assign fill_index = st.miss_addr[icache_pkg::tag_lsb-1:icache_pkg::line_lsb];
  assign fill_tag   = st.miss_addr[icache_pkg::addr_w-1:icache_pkg::tag_lsb];

  // empty way first, ages only break a full set
  always_comb begin
    if (!valid_mem[0][fill_index])
      fill_way = 1'b0;
    else if (!valid_mem[1][fill_index])
      fill_way = 1'b1;
    else
      fill_way = victim_way;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_mem[0] <= '0;
      valid_mem[1] <= '0;
    end else if (st.fill_valid) begin
      valid_mem[fill_way][fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (st.fill_valid) begin
      tag_mem[fill_way][fill_index]  <= fill_tag;
      line_mem[fill_way][fill_index] <= st.fill_line;
    end
  end

  // registered read port, both ways at once
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag[0]  <= tag_mem[0][rd_index];
      rd_tag[1]  <= tag_mem[1][rd_index];
      rd_line[0] <= line_mem[0][rd_index];
      rd_line[1] <= line_mem[1][rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      rd_valid <= 2'b00;
    else if (rd_en)
      rd_valid <= {valid_mem[1][rd_index], valid_mem[0][rd_index]};
  end

  assign way_tag0   = rd_tag[0];
  assign way_tag1   = rd_tag[1];
  assign way_line0  = rd_line[0];
  assign way_line1  = rd_line[1];
  assign way_valid0 = rd_valid[0];
  assign way_valid1 = rd_valid[1];

endmodule

// ==== rtl/refill_if.sv ====
`timescale 1ns/10ps

interface refill_if;

  logic              miss;
  icache_pkg::addr_t miss_addr;
  logic              fill_valid;
  icache_pkg::line_t fill_line;
  logic              busy;

  modport lookup (
    output miss, miss_addr,
    input  busy, fill_valid, fill_line
  );

  modport refill (
    input  miss, miss_addr,
    output busy, fill_valid, fill_line
  );

  // arrays and ages
  modport store (
    input fill_valid, fill_line, miss_addr
  );

endinterface

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

`include "icache_macros.svh"

  // one beat per line word
  localparam int beats = `ICACHE_LINE_WORDS;

  typedef logic [2:0] beat_cnt_t;

  localparam beat_cnt_t last_beat = beat_cnt_t'(beats - 1);

  typedef enum logic [1:0] {
    idle,
    fetch,
    write
  } refill_state_e;

endpackage

// ==== rtl/icache_pkg.sv ====
package icache_pkg;

`include "icache_macros.svh"

  localparam int addr_w     = `ICACHE_ADDR_W;
  localparam int word_w     = addr_w;
  localparam int sets       = `ICACHE_SETS;
  localparam int line_words = `ICACHE_LINE_WORDS;
  localparam int index_w    = $clog2(sets);
  localparam int offset_w   = $clog2(line_words);
  // byte offset within a word
  localparam int byte_w     = 3;
  localparam int line_lsb   = offset_w + byte_w;
  localparam int tag_lsb    = line_lsb + index_w;
  localparam int tag_w      = addr_w - tag_lsb;
  localparam int line_w     = line_words * word_w;

  typedef logic [addr_w-1:0]        addr_t;
  typedef logic [word_w-1:0]        word_t;
  typedef logic [tag_w-1:0]         tag_t;
  typedef logic [index_w-1:0]       index_t;
  typedef logic [offset_w-1:0]      offset_t;
  // word 0 sits in the low bits
  typedef logic [line_w-1:0]        line_t;
  typedef logic [`ICACHE_AGE_W-1:0] age_t;

endpackage

// ==== rtl/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// fetch address and word width
`define ICACHE_ADDR_W 64

// sets per way, one line per set
`define ICACHE_SETS 64

// 64-bit words in a 32-byte line
`define ICACHE_LINE_WORDS 4

// saturating age counter per set and way
`define ICACHE_AGE_W 4

`endif
